/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module bldc_driver_tb -f project.f
	./obj_dir/Vbldc_driver_tb | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

/* project.f */
rtl/bldc_pkg.sv
rtl/hall_status_if.sv
rtl/hall_monitor.sv
rtl/motor_control.sv
rtl/commutation_pwm.sv
rtl/bldc_driver.sv
sim/tb_clock.sv
sim/bldc_driver_tb.sv

/* rtl/bldc_driver.sv */
`timescale 1ns/1ps

module bldc_driver #(
    parameter int duty_width        = 10,
    parameter int dead_time         = 8,
    parameter int ramp_tick_width   = 12,
    parameter int ramp_step_width   = 7,
    parameter int hall_sample_width = 7,
    parameter int hall_steady_count = 120
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  en,
    input  logic                  direction,
    input  logic [2:0]            hall,
    input  logic [duty_width-1:0] duty_cycle,
    output logic [2:0]            phase_h,
    output logic [2:0]            phase_l,
    output logic                  connected,
    output logic                  fault
);

    // Controller to bridge, both registered in the controller
    logic                  drive_en;
    logic [duty_width-1:0] drive_duty;

    // Sensor status shared by all three blocks
    hall_status_if status_if ();

    // Synchronizer and sensor fault latches
    hall_monitor #(
        .hall_sample_width (hall_sample_width),
        .hall_steady_count (hall_steady_count)
    ) hall_monitor_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .hall_in   (hall),
        .status    (status_if.monitor),
        .connected (connected)
    );

    // Stop, ramp, run and fault recovery
    motor_control #(
        .duty_width      (duty_width),
        .ramp_tick_width (ramp_tick_width),
        .ramp_step_width (ramp_step_width)
    ) motor_control_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (en),
        .duty_cycle (duty_cycle),
        .status     (status_if.control),
        .drive_en   (drive_en),
        .drive_duty (drive_duty),
        .fault      (fault)
    );

    // Six-step decode and dead-time PWM for the three half-bridges
    commutation_pwm #(
        .duty_width (duty_width),
        .dead_time  (dead_time)
    ) commutation_pwm_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .status     (status_if.commutator),
        .direction  (direction),
        .drive_en   (drive_en),
        .drive_duty (drive_duty),
        .phase_h    (phase_h),
        .phase_l    (phase_l)
    );

endmodule

/* rtl/bldc_pkg.sv */
package bldc_pkg;

    // ==================================================
    // Vector types
    // ==================================================

    // One sampled hall code, bit 0 is the sensor for phase A
    typedef logic [2:0] hall_t;

    // One flag per motor phase, bit 0 is phase A
    typedef logic [2:0] phase_t;

    // Number of motor phases, fixed by the six-step scheme
    localparam int num_phases = 3;

    // ==================================================
    // Controller states
    // ==================================================

    // Stop holds the bridge off until a usable duty is requested
    // Startup ramps the duty from the minimum over a fixed number of ticks
    // Run passes the requested duty straight through
    // Poll waits for a disconnected sensor to deliver valid codes again
    // Err holds the bridge off after a stuck-low sensor
    typedef enum logic [2:0] {
        st_stop,
        st_startup,
        st_run,
        st_poll_hall,
        st_err
    } motor_state_t;

    // ==================================================
    // Hall codes that never occur on a healthy sensor
    // ==================================================

    // All lines low means a short or a dead sensor supply
    localparam hall_t hall_all_low = 3'b000;

    // The inputs have pull-ups, so all lines high means an open connector
    localparam hall_t hall_all_high = 3'b111;

endpackage

/* rtl/commutation_pwm.sv */
`timescale 1ns/1ps

module commutation_pwm #(
    parameter int duty_width = 10,
    parameter int dead_time  = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    hall_status_if.commutator     status,
    input  logic                  direction,
    input  logic                  drive_en,
    input  logic [duty_width-1:0] drive_duty,
    output bldc_pkg::phase_t      phase_h,
    output bldc_pkg::phase_t      phase_l
);
    import bldc_pkg::*;

    localparam int dt_w = $clog2(dead_time + 1);
    localparam logic [dt_w-1:0] dt_full = dt_w'(dead_time);

    phase_t                fwd_src;
    phase_t                fwd_snk;
    phase_t                src;
    phase_t                snk;
    phase_t                req_h;
    phase_t                req_l;
    logic [duty_width-1:0] carrier;
    logic                  pwm_on;
    logic [dt_w-1:0]       dt_cnt [num_phases];

    // ==================================================
    // Six-step commutation table
    // ==================================================

    // Forward table with one-hot source and sink and phase A in bit 0
    always_comb begin
        case (status.hall)
            3'b001:  {fwd_src, fwd_snk} = {3'b001, 3'b010};
            3'b011:  {fwd_src, fwd_snk} = {3'b001, 3'b100};
            3'b010:  {fwd_src, fwd_snk} = {3'b010, 3'b100};
            3'b110:  {fwd_src, fwd_snk} = {3'b010, 3'b001};
            3'b100:  {fwd_src, fwd_snk} = {3'b100, 3'b001};
            3'b101:  {fwd_src, fwd_snk} = {3'b100, 3'b010};
            // 000 and 111 leave every phase floating
            default: {fwd_src, fwd_snk} = '0;
        endcase
    end

    // Reverse rotation drives current the other way through the same pair
    assign src = direction ? fwd_src : fwd_snk;
    assign snk = direction ? fwd_snk : fwd_src;

    // ==================================================
    // Carrier and side requests
    // ==================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            carrier <= '0;
        end else begin
            carrier <= carrier + 1'b1;
        end
    end

    assign pwm_on = (carrier < drive_duty);

    // Source chops between high and low side, sink holds its low side on
    assign req_h = drive_en ? (src & {num_phases{pwm_on}}) : '0;
    assign req_l = drive_en ? (snk | (src & {num_phases{~pwm_on}})) : '0;

    // ==================================================
    // Dead time and output registers
    // ==================================================

    // dt_cnt counts clocks with both sides of a phase off and saturates at dead_time
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_h <= '0;
            phase_l <= '0;
            for (int i = 0; i < num_phases; i++) begin
                dt_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_phases; i++) begin
                // A side that is on stays on, a side that is off waits out the gap
                phase_h[i] <= req_h[i] && (phase_h[i] || (dt_cnt[i] == dt_full));
                phase_l[i] <= req_l[i] && (phase_l[i] || (dt_cnt[i] == dt_full));
                // The gap starts over on the clock a side comes on, not one later
                if (phase_h[i] || phase_l[i] ||
                    ((dt_cnt[i] == dt_full) && (req_h[i] || req_l[i]))) begin
                    dt_cnt[i] <= '0;
                end else if (dt_cnt[i] != dt_full) begin
                    dt_cnt[i] <= dt_cnt[i] + 1'b1;
                end
            end
        end
    end

    // Shoot-through on any half-bridge is never allowed
    a_no_shoot_through: assert property (@(posedge clk) disable iff (!arst_n)
        (phase_h & phase_l) == '0);

endmodule

/* rtl/hall_monitor.sv */
`timescale 1ns/1ps

module hall_monitor #(
    parameter int hall_sample_width = 7,
    parameter int hall_steady_count = 120
) (
    input  logic            clk,
    input  logic            arst_n,
    input  bldc_pkg::hall_t hall_in,
    hall_status_if.monitor  status,
    output logic            connected
);
    import bldc_pkg::*;

    localparam int cnt_w = $clog2(hall_steady_count + 1);
    // Count value reached on the last sample before a latch fires
    localparam logic [cnt_w-1:0] steady_last = cnt_w'(hall_steady_count - 1);
    localparam logic [cnt_w-1:0] steady_full = cnt_w'(hall_steady_count);

    hall_t                        hall_meta;
    hall_t                        hall_sync;
    logic [hall_sample_width-1:0] sample_cnt;
    logic                         sample_tick;
    logic [cnt_w-1:0]             low_cnt;
    logic [cnt_w-1:0]             high_cnt;
    logic [cnt_w-1:0]             valid_cnt;
    logic                         is_low;
    logic                         is_high;
    logic                         low_hit;
    logic                         high_hit;
    logic                         valid_hit;
    logic                         hw_fault_q;
    logic                         disc_q;

    // ==================================================
    // Input synchronizer and sample timer
    // ==================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hall_meta  <= '0;
            hall_sync  <= '0;
            sample_cnt <= '0;
        end else begin
            hall_meta  <= hall_in;
            hall_sync  <= hall_meta;
            // Free running, wraps every 2**hall_sample_width clocks
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    assign sample_tick = &sample_cnt;
    assign is_low      = (hall_sync == hall_all_low);
    assign is_high     = (hall_sync == hall_all_high);

    // A latch fires on the sample that completes the run of equal codes
    assign low_hit   = sample_tick && is_low && (low_cnt == steady_last);
    assign high_hit  = sample_tick && is_high && (high_cnt == steady_last);
    assign valid_hit = sample_tick && status.polling && !is_low && !is_high &&
                       (valid_cnt == steady_last);

    // ==================================================
    // Steady counters and fault latches
    // ==================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            low_cnt    <= '0;
            high_cnt   <= '0;
            valid_cnt  <= '0;
            hw_fault_q <= 1'b0;
            disc_q     <= 1'b0;
        end else begin
            if (sample_tick) begin
                // Counters saturate so that a held code fires its latch once
                low_cnt  <= !is_low ? '0 : (low_cnt == steady_full) ? low_cnt : low_cnt + 1'b1;
                high_cnt <= !is_high ? '0 :
                            (high_cnt == steady_full) ? high_cnt : high_cnt + 1'b1;
                // Valid codes only count while the controller polls
                if (!status.polling || is_low || is_high) begin
                    valid_cnt <= '0;
                end else if (valid_cnt != steady_full) begin
                    valid_cnt <= valid_cnt + 1'b1;
                end
            end
            if (low_hit) begin
                hw_fault_q <= 1'b1;
            end else if (status.fault_release) begin
                hw_fault_q <= 1'b0;
            end
            // Releasing a hardware fault leaves the sensor treated as unplugged
            if (high_hit || status.fault_release) begin
                disc_q <= 1'b1;
            end else if (valid_hit) begin
                disc_q <= 1'b0;
            end
        end
    end

    assign status.hall           = hall_sync;
    assign status.hardware_fault = hw_fault_q;
    assign status.disconnected   = disc_q;
    assign connected             = ~disc_q;

    // Both faults come from different codes, so they never start together
    a_fault_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !($rose(status.hardware_fault) && $rose(status.disconnected)));

endmodule

/* rtl/hall_status_if.sv */
`timescale 1ns/1ps

// Sensor status shared by the monitor, the controller and the commutator
interface hall_status_if;
    import bldc_pkg::*;

    // Synchronized hall code, already two flops away from the pins
    hall_t hall;

    // Latched sensor faults, both set by the monitor
    logic  hardware_fault;
    logic  disconnected;

    // Controller is waiting for the sensor to come back
    logic  polling;

    // Single-cycle pulse that trades a hardware fault for a disconnect
    logic  fault_release;

    modport monitor (
        output hall, hardware_fault, disconnected,
        input  polling, fault_release
    );

    modport control (
        input  hall, hardware_fault, disconnected,
        output polling, fault_release
    );

    // The bridge logic only needs the code itself
    modport commutator (input hall);

endinterface

/* rtl/motor_control.sv */
`timescale 1ns/1ps

module motor_control #(
    parameter int duty_width      = 10,
    parameter int ramp_tick_width = 12,
    parameter int ramp_step_width = 7
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  en,
    input  logic [duty_width-1:0] duty_cycle,
    hall_status_if.control        status,
    output logic                  drive_en,
    output logic [duty_width-1:0] drive_duty,
    output logic                  fault
);
    import bldc_pkg::*;

    // Minimum usable duty is 5 % of full scale rounded down
    localparam int unsigned full_scale = (1 << duty_width) - 1;
    localparam logic [duty_width-1:0] min_duty = duty_width'(full_scale * 5 / 100);
    // Step count at the start of the last ramp tick
    localparam logic [ramp_step_width-1:0] ramp_last =
        ramp_step_width'((1 << ramp_step_width) - 2);

    motor_state_t               state;
    motor_state_t               state_next;
    logic [ramp_tick_width-1:0] tick_cnt;
    logic [ramp_step_width-1:0] step_cnt;
    logic                       tick_done;
    logic                       err_exit;

    assign tick_done = &tick_cnt;

    // Pulling the sensor out while in error is the way to clear a hardware fault
    assign err_exit = en && (state == st_err) && (status.hall == hall_all_high);

    // ==================================================
    // Next state
    // ==================================================

    always_comb begin
        state_next = state;
        if (!en) begin
            state_next = st_stop;
        end else if (state == st_err) begin
            if (err_exit) begin
                state_next = st_poll_hall;
            end
        end else if (status.hardware_fault) begin
            state_next = st_err;
        end else if (status.disconnected) begin
            state_next = st_poll_hall;
        end else begin
            case (state)
                st_stop: begin
                    if (duty_cycle > min_duty) begin
                        state_next = st_startup;
                    end
                end
                st_startup: begin
                    if (duty_cycle <= min_duty) begin
                        state_next = st_stop;
                    end else if (tick_done && (step_cnt == ramp_last)) begin
                        state_next = st_run;
                    end
                end
                st_run: begin
                    if (duty_cycle <= min_duty) begin
                        state_next = st_stop;
                    end
                end
                // Disconnect has cleared when we get here, so restart from stop
                default: state_next = st_stop;
            endcase
        end
    end

    // ==================================================
    // State register, ramp counters and outputs
    // ==================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_stop;
            tick_cnt   <= '0;
            step_cnt   <= '0;
            drive_duty <= '0;
            drive_en   <= 1'b0;
            fault      <= 1'b0;
        end else begin
            state    <= state_next;
            drive_en <= (state_next == st_startup) || (state_next == st_run);
            // Raised one clock after entering error, dropped on the way out
            fault    <= (state == st_err) && (state_next == st_err);
            case (state_next)
                st_startup: begin
                    if (state != st_startup) begin
                        // Fresh ramp from the minimum duty
                        tick_cnt   <= '0;
                        step_cnt   <= '0;
                        drive_duty <= min_duty;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_done) begin
                            step_cnt <= step_cnt + 1'b1;
                            // The ramp never overshoots a small request
                            if (drive_duty < duty_cycle) begin
                                drive_duty <= drive_duty + 1'b1;
                            end
                        end
                    end
                end
                st_run:  drive_duty <= duty_cycle;
                default: drive_duty <= '0;
            endcase
        end
    end

    assign status.polling       = (state == st_poll_hall);
    assign status.fault_release = err_exit;

    // A sensor fault turns the bridge off on the next clock, and neither error
    // nor polling hands over to a driving state without passing through stop
    a_no_drive_on_fault: assert property (@(posedge clk) disable iff (!arst_n)
        ((state == st_err) || (state == st_poll_hall) ||
         status.hardware_fault || status.disconnected) |=> !drive_en);

endmodule

/* sim/bldc_driver_tb.sv */
`timescale 1ns/1ps

module bldc_driver_tb;

    // ==================================================
    // DUT settings and test lengths
    // ==================================================

    localparam int duty_width        = 10;
    localparam int dead_time         = 8;
    localparam int ramp_tick_width   = 4;
    localparam int ramp_step_width   = 4;
    localparam int hall_sample_width = 3;
    localparam int hall_steady_count = 6;
    localparam int settle_cycles     = 20;
    localparam int hold_cycles       = 1200;
    localparam int max_hold          = 1000;
    localparam int ramp_wait         = 300;
    localparam int ramp_cycles = (1 << ramp_tick_width) * ((1 << ramp_step_width) - 1);
    // Idle run, ramp, twelve commutation holds, three random holds, then slack for the fault waits
    localparam int timeout_cycles = 500 + ramp_wait + 12 * hold_cycles + 3 * max_hold + 1800;
    localparam int sel_fault     = 0;
    localparam int sel_connected = 1;
    localparam int sel_source    = 2;

    logic                  clk;
    logic                  arst_n;
    logic                  en;
    logic                  direction;
    logic [2:0]            hall;
    logic [duty_width-1:0] duty_cycle;
    logic [2:0]            phase_h;
    logic [2:0]            phase_l;
    logic                  connected;
    logic                  fault;

    int         cyc = 0;
    int         stim_errors = 0;
    int         mon_errors = 0;
    int         seg = 0;
    int         prev_seg = -1;
    int         age = 0;
    bit         chk_comm = 1'b0;
    bit         seen_h;
    bit         seen_l;
    logic [2:0] exp_src;
    logic [2:0] exp_snk;
    logic [2:0] exp_flt;
    int         last_h [3] = '{-100, -100, -100};
    int         last_l [3] = '{-100, -100, -100};
    string      test_name = "reset";
    logic [2:0] valid_codes [6] = '{3'b001, 3'b011, 3'b010, 3'b110, 3'b100, 3'b101};

    tb_clock clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    bldc_driver #(
        .duty_width        (duty_width),
        .dead_time         (dead_time),
        .ramp_tick_width   (ramp_tick_width),
        .ramp_step_width   (ramp_step_width),
        .hall_sample_width (hall_sample_width),
        .hall_steady_count (hall_steady_count)
    ) dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (en),
        .direction  (direction),
        .hall       (hall),
        .duty_cycle (duty_cycle),
        .phase_h    (phase_h),
        .phase_l    (phase_l),
        .connected  (connected),
        .fault      (fault)
    );

    // ==================================================
    // Reference model and helpers
    // ==================================================

    // Six-step table, upper field is the source phase and lower field the sink
    function automatic void expected_phases(input logic [2:0] code, input logic dir,
                                            output logic [2:0] src, output logic [2:0] snk,
                                            output logic [2:0] flt);
        logic [3:0] pair;
        case (code)
            3'b001:  pair = {2'd0, 2'd1};
            3'b011:  pair = {2'd0, 2'd2};
            3'b010:  pair = {2'd1, 2'd2};
            3'b110:  pair = {2'd1, 2'd0};
            3'b100:  pair = {2'd2, 2'd0};
            3'b101:  pair = {2'd2, 2'd1};
            default: pair = 4'hf;
        endcase
        src = 3'b000;
        snk = 3'b000;
        // Reverse rotation swaps which of the two phases sources the current
        if (pair != 4'hf) begin
            src[dir ? pair[3:2] : pair[1:0]] = 1'b1;
            snk[dir ? pair[1:0] : pair[3:2]] = 1'b1;
        end
        flt = ~(src | snk);
    endfunction

    function automatic int mismatch(input string what, input int expected, input int actual);
        int bad;
        bad = 0;
        assert (actual == expected) else begin
            $display("error %s: %s expected %0h, got %0h", test_name, what, expected, actual);
            bad = 1;
        end
        return bad;
    endfunction

    // Current value of one of the conditions the stimulus waits on
    function automatic logic probe(input int sel);
        logic [2:0] s;
        logic [2:0] k;
        logic [2:0] f;
        if (sel == sel_fault) return fault;
        if (sel == sel_connected) return connected;
        expected_phases(hall, direction, s, k, f);
        return |((phase_h | phase_l) & s);
    endfunction

    task automatic wait_until(input int sel, input logic level, input int limit,
                              input string what);
        int n;
        n = 0;
        while (probe(sel) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (probe(sel) === level) else begin
            $display("%s: %s did not happen within %0d cycles", test_name, what, limit);
            stim_errors++;
        end
    endtask

    // A new segment restarts the settle window and the source activity flags
    task automatic hold_code(input logic [2:0] code, input logic dir, input int cycles,
                             input bit both_sides);
        hall      = code;
        direction = dir;
        seg++;
        repeat (cycles) @(negedge clk);
        // A full-length hold spans a whole carrier period
        if (both_sides) begin
            stim_errors += mismatch("source high and low side", 3, int'({seen_h, seen_l}));
        end else begin
            stim_errors += mismatch("source active", 1, int'(seen_h || seen_l));
        end
    endtask

    // ==================================================
    // Output checker, runs on every rising edge
    // ==================================================

    always @(posedge clk) begin
        if (arst_n) begin
            mon_errors += mismatch("phase_h and phase_l overlap", 0, int'(phase_h & phase_l));
            for (int i = 0; i < 3; i++) begin
                // Each side must wait out the dead time after the other side went off
                if (phase_l[i]) begin
                    assert (cyc - last_h[i] > dead_time) else begin
                        $display("phase %0d low side came on %0d cycles after its high side",
                                 i, cyc - last_h[i]);
                        mon_errors++;
                    end
                end
                if (phase_h[i]) begin
                    assert (cyc - last_l[i] > dead_time) else begin
                        $display("phase %0d high side came on %0d cycles after its low side",
                                 i, cyc - last_l[i]);
                        mon_errors++;
                    end
                end
                if (phase_h[i]) last_h[i] = cyc;
                if (phase_l[i]) last_l[i] = cyc;
            end
            if (seg != prev_seg) begin
                age      = 0;
                seen_h   = 1'b0;
                seen_l   = 1'b0;
                prev_seg = seg;
            end else if (age < settle_cycles) begin
                age++;
            end
            // Skip the sync delay and the dead time after each new code
            if (chk_comm && age >= settle_cycles) begin
                expected_phases(hall, direction, exp_src, exp_snk, exp_flt);
                mon_errors += mismatch("phase_h off source", 0, int'(phase_h & ~exp_src));
                mon_errors += mismatch("phase_l on floating", 0, int'(phase_l & exp_flt));
                mon_errors += mismatch("phase_l on sink", int'(exp_snk), int'(phase_l & exp_snk));
                if ((phase_h & exp_src) != 3'b000) seen_h = 1'b1;
                if ((phase_l & exp_src) != 3'b000) seen_l = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        int k;
        int hold;
        k          = int'($urandom(32'h7998));
        en         = 1'b0;
        direction  = 1'b1;
        hall       = 3'b001;
        duty_cycle = '0;
        wait (arst_n === 1'b1);
        @(negedge clk);

        // Quiet outputs after reset, and no drive at the minimum duty
        stim_errors += mismatch("phase outputs", 0, int'({phase_h, phase_l}));
        stim_errors += mismatch("fault", 0, int'(fault));
        stim_errors += mismatch("connected", 1, int'(connected));
        test_name  = "minimum duty";
        en         = 1'b1;
        duty_cycle = 10'd51;
        repeat (500) begin
            @(negedge clk);
            stim_errors += mismatch("phase outputs", 0, int'({phase_h, phase_l}));
        end

        // All six codes in both directions, the reverse pass walks the table backwards
        test_name  = "commutation";
        duty_cycle = 10'd600;
        repeat (ramp_wait) @(negedge clk);
        chk_comm = 1'b1;
        for (int d = 1; d >= 0; d--) begin
            for (int c = 0; c < 6; c++) begin
                hold_code(valid_codes[d ? c : 5 - c], 1'(d), hold_cycles, 1'b1);
            end
        end
        chk_comm = 1'b0;

        // Stuck-low sensor latches the fault, pulling the connector releases it
        test_name = "hardware fault";
        hall      = 3'b000;
        wait_until(sel_fault, 1'b1, 150, "fault after hall 000");
        repeat (100) begin
            stim_errors += mismatch("phase outputs", 0, int'({phase_h, phase_l}));
            stim_errors += mismatch("fault while 000 held", 1, int'(fault));
            @(negedge clk);
        end
        hall = 3'b111;
        wait_until(sel_fault, 1'b0, 150, "fault release after hall 111");
        wait_until(sel_connected, 1'b0, 150, "disconnect after fault release");
        hall = 3'b001;
        wait_until(sel_connected, 1'b1, 150, "reconnect after fault");
        repeat (ramp_wait) @(negedge clk);

        // Open connector while running, then valid codes bring the drive back
        test_name = "disconnect";
        hall      = 3'b111;
        wait_until(sel_connected, 1'b0, 150, "disconnect on hall 111");
        stim_errors += mismatch("fault", 0, int'(fault));
        stim_errors += mismatch("phase outputs", 0, int'({phase_h, phase_l}));
        hall = 3'b011;
        wait_until(sel_connected, 1'b1, 150, "reconnect on valid codes");
        wait_until(sel_source, 1'b1, ramp_cycles + 150, "source PWM after reconnect");

        // Random codes, directions and duties above the minimum
        test_name = "random";
        chk_comm  = 1'b1;
        repeat (3) begin
            k          = int'($urandom % 6);
            hold       = int'(200 + $urandom % 801);
            duty_cycle = 10'(52 + $urandom % 900);
            hold_code(valid_codes[k], 1'($urandom % 2), hold, 1'b0);
        end
        chk_comm = 1'b0;

        $display("errors: stimulus %0d, monitor %0d", stim_errors, mon_errors);
        if (stim_errors + mon_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

// Free-running clock and power-on reset for the testbench
module tb_clock #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Reset is held for a fixed number of cycles and let go on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule
